/* common/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// boot ROM entry in kseg1
`define RESET_PC        32'hbfc00000

// general exception entry while BEV is set
`define EXC_VECTOR      32'hbfc00380

// coprocessor 0 register numbers as seen by mfc0 and mtc0
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_CONFIG      5'd16

// BEV is bit 22 and ERL is bit 2 while everything else starts cleared
`define STATUS_INIT     32'h00400004

// M is set so a Config1 would follow while BE is 0 and kseg0 is uncached
`define CONFIG_INIT     32'h80000002

`endif

/* common/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [4:0]  creg_addr_t;  // register number field of mfc0/mtc0
    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [8:0] zero_31_23;
        logic       bev;          // bootstrap vectors
        logic [5:0] zero_21_16;
        logic [7:0] im;           // one mask bit per Cause.IP line
        logic [4:0] zero_7_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic        bd;           // victim sat in a branch delay slot
        logic        ti;           // mirrors the timer interrupt
        logic [13:0] zero_29_16;
        // ip[1:0] are the software bits, ip[6:2] the hardware lines, ip[7] the timer
        logic [7:0]  ip;
        logic        zero_7;
        logic [4:0]  exccode;
        logic [1:0]  zero_1_0;
    } cause_t;

    typedef struct packed {
        word_t   badvaddr;
        word_t   count;
        word_t   compare;
        status_t status;
        cause_t  cause;
        word_t   epc;
        word_t   config_;  // underscore because config is a keyword
    } cp0_regs_t;

endpackage

/* common/excep_pkg.sv */
package excep_pkg;

    // values are the architectural Cause.ExcCode encodings
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,   // address error on fetch or load
        ADES = 5'd5,   // address error on store
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exccode_t;

    // one record per committing instruction that only means something when valid is set
    typedef struct packed {
        logic           valid;
        exccode_t       code;
        cp0_pkg::word_t pc;
        logic           in_delay_slot;
        cp0_pkg::word_t badvaddr;
    } exception_t;

endpackage

/* rtl/exception_unit.sv */
`timescale 1ns/1ps

module exception_unit (
    input  logic                  commit_valid,
    input  cp0_pkg::word_t        commit_pc,
    input  logic                  in_delay_slot,
    input  logic                  fetch_adel,
    input  cp0_pkg::word_t        fetch_addr,
    input  logic                  ri,
    input  logic                  ov,
    input  logic                  syscall,
    input  logic                  brk,
    input  logic                  load_adel,
    input  logic                  store_ades,
    input  cp0_pkg::word_t        mem_addr,
    input  logic [7:0]            pending_int,
    input  cp0_pkg::status_t      status,
    input  logic                  cwrite_en_in,
    input  logic                  is_eret_in,
    output excep_pkg::exception_t exception,
    output logic                  cwrite_en,
    output logic                  is_eret
);
    import excep_pkg::*;

    logic int_taken;

    // interrupts are blocked inside a handler and while ERL is set
    assign int_taken = commit_valid && (|pending_int) && status.ie
                       && ~status.exl && ~status.erl;

    always_comb begin
        exception.valid         = 1'b0;
        exception.code          = INT;
        exception.pc            = commit_pc;
        exception.in_delay_slot = in_delay_slot;
        exception.badvaddr      = '0;

        // highest priority first
        if (commit_valid) begin
            if (int_taken) begin
                exception.valid = 1'b1;
                exception.code  = INT;
            end else if (fetch_adel) begin
                exception.valid    = 1'b1;
                exception.code     = ADEL;
                exception.badvaddr = fetch_addr;
            end else if (ri) begin
                exception.valid = 1'b1;
                exception.code  = RI;
            end else if (ov) begin
                exception.valid = 1'b1;
                exception.code  = OV;
            end else if (syscall) begin
                exception.valid = 1'b1;
                exception.code  = SYS;
            end else if (brk) begin
                exception.valid = 1'b1;
                exception.code  = BP;
            end else if (load_adel) begin
                exception.valid    = 1'b1;
                exception.code     = ADEL;
                exception.badvaddr = mem_addr;
            end else if (store_ades) begin
                exception.valid    = 1'b1;
                exception.code     = ADES;
                exception.badvaddr = mem_addr;
            end
        end
    end

    // a faulting instruction never completes its mtc0 or eret
    assign cwrite_en = cwrite_en_in & ~exception.valid;
    assign is_eret   = is_eret_in & ~exception.valid;

endmodule

/* cp0/cp0.sv */
`timescale 1ns/1ps

`include "mips_defs.svh"

module cp0 (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  cwrite_en,
    input  cp0_pkg::creg_addr_t   cwrite_addr,
    input  cp0_pkg::word_t        cwrite_data,
    input  cp0_pkg::creg_addr_t   read_addr,
    input  logic                  is_eret,
    input  excep_pkg::exception_t exception,
    input  logic [4:0]            hw_int,
    output cp0_pkg::word_t        read_data,
    output cp0_pkg::status_t      status,
    output logic [7:0]            pending_int,
    output cp0_pkg::word_t        epc,
    output logic                  timer_interrupt
);
    import cp0_pkg::*;
    import excep_pkg::*;

    localparam cp0_regs_t REGS_INIT = '{
        badvaddr: '0,
        count:    '0,
        compare:  '0,
        status:   status_t'(`STATUS_INIT),
        cause:    '0,
        epc:      '0,
        config_:  `CONFIG_INIT
    };

    cp0_regs_t regs;
    cp0_regs_t regs_new;
    logic      count_switch;  // Count moves on every other clock

    always_ff @(posedge clk) begin
        if (~resetn) begin
            regs <= REGS_INIT;
        end else begin
            regs <= regs_new;
        end
    end

    always_ff @(posedge clk) begin
        if (~resetn) begin
            count_switch <= 1'b0;
        end else begin
            count_switch <= ~count_switch;
        end
    end

    // the mfc0 path has no register stage
    always_comb begin
        case (read_addr)
            `CP0_BADVADDR: read_data = regs.badvaddr;
            `CP0_COUNT:    read_data = regs.count;
            `CP0_COMPARE:  read_data = regs.compare;
            `CP0_STATUS:   read_data = regs.status;
            `CP0_CAUSE:    read_data = regs.cause;
            `CP0_EPC:      read_data = regs.epc;
            `CP0_CONFIG:   read_data = regs.config_;
            default:       read_data = '0;
        endcase
    end

    // set wins over the clear from a Compare write in the same cycle
    always_ff @(posedge clk) begin
        if (~resetn) begin
            timer_interrupt <= 1'b0;
        end else if (regs_new.count == regs_new.compare) begin
            timer_interrupt <= 1'b1;
        end else if (cwrite_en && cwrite_addr == `CP0_COMPARE) begin
            timer_interrupt <= 1'b0;
        end
    end

    always_comb begin
        regs_new = regs;

        regs_new.count = regs.count + {31'b0, count_switch};

        // hardware lines are sampled every cycle
        regs_new.cause.ip[6:2] = hw_int;
        regs_new.cause.ip[7]   = timer_interrupt;
        regs_new.cause.ti      = timer_interrupt;

        if (cwrite_en) begin
            case (cwrite_addr)
                `CP0_COUNT:   regs_new.count   = cwrite_data;
                `CP0_COMPARE: regs_new.compare = cwrite_data;
                `CP0_STATUS: begin
                    regs_new.status.im  = cwrite_data[15:8];
                    regs_new.status.exl = cwrite_data[1];
                    regs_new.status.ie  = cwrite_data[0];
                end
                `CP0_CAUSE:   regs_new.cause.ip[1:0] = cwrite_data[9:8];
                `CP0_EPC:     regs_new.epc     = cwrite_data;
                default: ;  // BadVAddr and Config are read only
            endcase
        end

        if (exception.valid) begin
            // a nested exception keeps the first EPC and BD
            if (~regs.status.exl) begin
                if (exception.in_delay_slot) begin
                    regs_new.cause.bd = 1'b1;
                    regs_new.epc      = exception.pc - 32'd4;  // restart at the branch
                end else begin
                    regs_new.cause.bd = 1'b0;
                    regs_new.epc      = exception.pc;
                end
            end
            regs_new.cause.exccode = exception.code;
            regs_new.status.exl    = 1'b1;
            if (exception.code == ADEL || exception.code == ADES) begin
                regs_new.badvaddr = exception.badvaddr;
            end
        end

        if (is_eret) begin
            if (regs.status.erl) begin
                regs_new.status.erl = 1'b0;
            end else begin
                regs_new.status.exl = 1'b0;
            end
        end
    end

    assign status      = regs.status;
    assign pending_int = regs.cause.ip & regs.status.im;
    assign epc         = regs.epc;

endmodule

/* rtl/pc_select.sv */
`timescale 1ns/1ps

`include "mips_defs.svh"

module pc_select (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  commit_valid,
    input  logic                  branch_taken,
    input  cp0_pkg::word_t        branch_target,
    input  excep_pkg::exception_t exception,
    input  logic                  is_eret,
    input  cp0_pkg::word_t        epc,
    output cp0_pkg::word_t        fetch_pc,
    output logic                  exc_taken
);

    logic [31:0] next_pc;

    // an exception wins over eret, which wins over a branch
    always_comb begin
        if (exception.valid) begin
            next_pc = `EXC_VECTOR;
        end else if (is_eret) begin
            next_pc = epc;
        end else if (commit_valid && branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = fetch_pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (~resetn) begin
            fetch_pc  <= `RESET_PC;
            exc_taken <= 1'b0;
        end else begin
            fetch_pc  <= next_pc;
            exc_taken <= exception.valid;  // high while fetch_pc holds the vector
        end
    end

endmodule

/* rtl/cp0_top.sv */
`timescale 1ns/1ps

module cp0_top (
    input  logic                clk,
    input  logic                resetn,
    // commit stage
    input  logic                commit_valid,
    input  cp0_pkg::word_t      commit_pc,
    input  logic                in_delay_slot,
    input  logic                fetch_adel,
    input  cp0_pkg::word_t      fetch_addr,
    input  logic                ri,
    input  logic                ov,
    input  logic                syscall,
    input  logic                brk,
    input  logic                load_adel,
    input  logic                store_ades,
    input  cp0_pkg::word_t      mem_addr,
    input  logic                branch_taken,
    input  cp0_pkg::word_t      branch_target,
    input  logic                cwrite_en,
    input  cp0_pkg::creg_addr_t cwrite_addr,
    input  cp0_pkg::word_t      cwrite_data,
    input  cp0_pkg::creg_addr_t read_addr,
    input  logic                is_eret,
    input  logic [4:0]          hw_int,
    output cp0_pkg::word_t      read_data,
    output cp0_pkg::word_t      fetch_pc,
    output logic                exc_taken,
    output logic                timer_interrupt
);
    import cp0_pkg::*;
    import excep_pkg::*;

    exception_t exception;
    status_t    status;
    word_t      epc;
    logic [7:0] pending_int;
    logic       cwrite_en_ok;   // mtc0 enable after fault gating
    logic       is_eret_ok;

    exception_unit u_exception_unit (
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .in_delay_slot (in_delay_slot),
        .fetch_adel    (fetch_adel),
        .fetch_addr    (fetch_addr),
        .ri            (ri),
        .ov            (ov),
        .syscall       (syscall),
        .brk           (brk),
        .load_adel     (load_adel),
        .store_ades    (store_ades),
        .mem_addr      (mem_addr),
        .pending_int   (pending_int),
        .status        (status),
        .cwrite_en_in  (cwrite_en),
        .is_eret_in    (is_eret),
        .exception     (exception),
        .cwrite_en     (cwrite_en_ok),
        .is_eret       (is_eret_ok)
    );

    cp0 u_cp0 (
        .clk             (clk),
        .resetn          (resetn),
        .cwrite_en       (cwrite_en_ok),
        .cwrite_addr     (cwrite_addr),
        .cwrite_data     (cwrite_data),
        .read_addr       (read_addr),
        .is_eret         (is_eret_ok),
        .exception       (exception),
        .hw_int          (hw_int),
        .read_data       (read_data),
        .status          (status),
        .pending_int     (pending_int),
        .epc             (epc),
        .timer_interrupt (timer_interrupt)
    );

    pc_select u_pc_select (
        .clk           (clk),
        .resetn        (resetn),
        .commit_valid  (commit_valid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exception     (exception),
        .is_eret       (is_eret_ok),
        .epc           (epc),
        .fetch_pc      (fetch_pc),
        .exc_taken     (exc_taken)
    );

endmodule

/* sim/tb_cp0_top.sv */
`timescale 1ns/1ps

`include "mips_defs.svh"

module tb_cp0_top;
    import cp0_pkg::*;
    import excep_pkg::*;

    logic       clk = 1'b0;
    logic       resetn;
    logic       commit_valid, in_delay_slot, fetch_adel, ri, ov, syscall, brk;
    logic       load_adel, store_ades, branch_taken, cwrite_en, is_eret;
    word_t      commit_pc, fetch_addr, mem_addr, branch_target, cwrite_data;
    creg_addr_t cwrite_addr, read_addr;
    logic [4:0] hw_int;
    word_t      read_data, fetch_pc;
    logic       exc_taken, timer_interrupt;

    cp0_regs_t   m;               // model of the register set
    logic        m_switch, m_timer, m_exc_taken, seen_timer;
    word_t       m_pc;
    int          checks = 0;
    int          errors = 0;
    int          test_start = 0;
    logic [31:0] rand_state = 32'hce27;
    creg_addr_t  reg_nums [0:7] = '{`CP0_BADVADDR, `CP0_COUNT, `CP0_COMPARE, `CP0_STATUS,
                                    `CP0_CAUSE, `CP0_EPC, `CP0_CONFIG, 5'd0};

    cp0_top DUT (.*);

    always #20 clk = ~clk;

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {rand_state[15:0], rand_state[31:16]};  // low LCG bits repeat quickly
    endfunction

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] model_read(input creg_addr_t a);
        case (a)
            `CP0_BADVADDR: return m.badvaddr;
            `CP0_COUNT:    return m.count;
            `CP0_COMPARE:  return m.compare;
            `CP0_STATUS:   return m.status;
            `CP0_CAUSE:    return m.cause;
            `CP0_EPC:      return m.epc;
            `CP0_CONFIG:   return m.config_;
            default:       return 32'h0;
        endcase
    endfunction

    // advance the model by one clock edge using the inputs of this cycle
    task automatic model_step();
        cp0_regs_t n;
        logic      take_int;
        logic      exc;
        logic      we;
        logic      er;
        exccode_t  code;
        word_t     bva;
        n = m;
        take_int = commit_valid && (|(m.cause.ip & m.status.im)) && m.status.ie
                   && !m.status.exl && !m.status.erl;
        exc = take_int || (commit_valid && (fetch_adel || ri || ov || syscall || brk
                                            || load_adel || store_ades));
        code = ADES;  // lowest priority first so later lines override
        bva  = mem_addr;
        if (load_adel) code = ADEL;
        if (brk) code = BP;
        if (syscall) code = SYS;
        if (ov) code = OV;
        if (ri) code = RI;
        if (fetch_adel) begin
            code = ADEL;
            bva  = fetch_addr;
        end
        if (take_int) code = INT;
        we = cwrite_en && !exc;
        er = is_eret && !exc;
        n.count         = m.count + (m_switch ? 32'd1 : 32'd0);
        n.cause.ip[6:2] = hw_int;
        n.cause.ip[7]   = m_timer;
        n.cause.ti      = m_timer;
        if (we && cwrite_addr == `CP0_COUNT) n.count = cwrite_data;
        if (we && cwrite_addr == `CP0_COMPARE) n.compare = cwrite_data;
        if (we && cwrite_addr == `CP0_EPC) n.epc = cwrite_data;
        if (we && cwrite_addr == `CP0_CAUSE) n.cause.ip[1:0] = cwrite_data[9:8];
        if (we && cwrite_addr == `CP0_STATUS) begin
            n.status.im  = cwrite_data[15:8];
            n.status.exl = cwrite_data[1];
            n.status.ie  = cwrite_data[0];
        end
        if (exc) begin
            if (!m.status.exl) begin
                n.cause.bd = in_delay_slot;
                n.epc      = in_delay_slot ? commit_pc - 32'd4 : commit_pc;
            end
            n.cause.exccode = code;
            n.status.exl    = 1'b1;
            if (code == ADEL || code == ADES) n.badvaddr = bva;
        end
        if (er && m.status.erl) n.status.erl = 1'b0;
        else if (er) n.status.exl = 1'b0;
        if (n.count == n.compare) m_timer = 1'b1;
        else if (we && cwrite_addr == `CP0_COMPARE) m_timer = 1'b0;
        if (exc) m_pc = `EXC_VECTOR;
        else if (er) m_pc = m.epc;
        else if (commit_valid && branch_taken) m_pc = branch_target;
        else m_pc = m_pc + 32'd4;
        m_exc_taken = exc;
        m_switch    = !m_switch;
        m           = n;
    endtask

    // runs at the falling edge, then waits for the next rising edge
    task automatic step_checked();
        seen_timer = timer_interrupt;
        compare("fetch_pc", fetch_pc, m_pc);
        compare("exc_taken", 32'(exc_taken), 32'(m_exc_taken));
        compare("timer_interrupt", 32'(timer_interrupt), 32'(m_timer));
        compare($sformatf("mfc0 of register %0d", read_addr), read_data, model_read(read_addr));
        model_step();
        @(posedge clk);
    endtask

    task automatic tick();
        @(negedge clk);
        step_checked();
    endtask

    task automatic set_idle();
        commit_valid  <= 1'b0;
        in_delay_slot <= 1'b0;
        fetch_adel    <= 1'b0;
        ri            <= 1'b0;
        ov            <= 1'b0;
        syscall       <= 1'b0;
        brk           <= 1'b0;
        load_adel     <= 1'b0;
        store_ades    <= 1'b0;
        branch_taken  <= 1'b0;
        cwrite_en     <= 1'b0;
        is_eret       <= 1'b0;
    endtask

    task automatic check_field(input string what, input creg_addr_t addr,
                               input logic [31:0] mask, input logic [31:0] exp);
        set_idle();
        read_addr <= addr;
        @(negedge clk);
        compare(what, read_data & mask, exp);
        step_checked();
    endtask

    task automatic mtc0(input creg_addr_t addr, input word_t data);
        set_idle();
        cwrite_en   <= 1'b1;
        cwrite_addr <= addr;
        cwrite_data <= data;
        tick();
    endtask

    task automatic random_instr(input logic faults_on, input logic [3:0] fault_mask);
        logic [31:0] r;
        logic [31:0] w;
        r = next_rand();
        w = next_rand();
        set_idle();
        commit_valid  <= r[0] | r[1];  // mostly valid
        commit_pc     <= {w[31:2], 2'b00};
        in_delay_slot <= r[2];
        branch_taken  <= r[3];
        branch_target <= {w[15:0], w[31:18], 2'b00};
        cwrite_en     <= r[4] & r[5];
        cwrite_addr   <= reg_nums[r[10:8]];
        cwrite_data   <= next_rand();
        read_addr     <= reg_nums[r[13:11]];
        fetch_addr    <= w ^ 32'h5555aaaa;
        mem_addr      <= ~w;
        if (faults_on && (r[19:16] & fault_mask) == 4'd0) begin
            case (r[22:20])
                3'd0: fetch_adel <= 1'b1;
                3'd1: ri <= 1'b1;
                3'd2: ov <= 1'b1;
                3'd3: syscall <= 1'b1;
                3'd4: brk <= 1'b1;
                3'd5: load_adel <= 1'b1;
                3'd6: store_ades <= 1'b1;
                default: begin
                    ri        <= 1'b1;
                    load_adel <= 1'b1;
                end
            endcase
        end
        tick();
    endtask

    // bounded wait on the timer output as seen at the falling edge
    task automatic wait_timer(input logic level);
        int n;
        n = 0;
        tick();
        while (seen_timer !== level && n < 64) begin
            tick();
            n++;
        end
        if (seen_timer !== level) begin
            errors++;
            $display("timeout: timer_interrupt did not reach %0b within 64 cycles", level);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        int          i;
        logic [31:0] r;
        resetn <= 1'b0;
        set_idle();
        commit_pc     <= 32'h0;
        fetch_addr    <= 32'h0;
        mem_addr      <= 32'h0;
        branch_target <= 32'h0;
        cwrite_addr   <= 5'd0;
        cwrite_data   <= 32'h0;
        read_addr     <= `CP0_COUNT;
        hw_int        <= 5'd0;
        m           = '0;
        m.status    = `STATUS_INIT;
        m.config_   = `CONFIG_INIT;
        m_switch    = 1'b0;
        m_timer     = 1'b0;
        m_exc_taken = 1'b0;
        m_pc        = `RESET_PC;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        @(negedge clk);
        compare("fetch_pc after reset", fetch_pc, `RESET_PC);
        compare("count after reset", read_data, 32'd0);
        step_checked();
        check_field("status after reset", `CP0_STATUS, 32'hffffffff, `STATUS_INIT);
        check_field("count two edges later", `CP0_COUNT, 32'hffffffff, 32'd1);
        check_field("config after reset", `CP0_CONFIG, 32'hffffffff, `CONFIG_INIT);
        for (i = 0; i < 10; i++) tick();
        report_test("reset and count");

        for (i = 0; i < 300; i++) random_instr(1'b0, 4'd0);
        for (i = 0; i < 8; i++) begin
            check_field("sweep", reg_nums[3'(i)], 32'hffffffff,
                        model_read(reg_nums[3'(i)]));
        end
        check_field("status fixed bits", `CP0_STATUS, 32'hffbf00f8, 32'h0);
        check_field("cause fixed bits", `CP0_CAUSE, 32'h3fff0083, 32'h0);
        check_field("config after writes", `CP0_CONFIG, 32'hffffffff, `CONFIG_INIT);
        report_test("mtc0 and mfc0");

        for (i = 0; i < 300; i++) random_instr(1'b1, 4'b0011);
        report_test("faults");

        set_idle();
        commit_valid <= 1'b1;
        is_eret      <= 1'b1;
        tick();
        check_field("erl cleared by eret", `CP0_STATUS, 32'h4, 32'h0);
        mtc0(`CP0_STATUS, 32'h00000002);
        set_idle();
        commit_valid <= 1'b1;
        is_eret      <= 1'b1;
        tick();
        check_field("exl cleared by eret", `CP0_STATUS, 32'h2, 32'h0);
        for (i = 0; i < 200; i++) random_instr(1'b0, 4'd0);
        report_test("eret and branches");

        mtc0(`CP0_STATUS, 32'h00008001);  // IM7 and IE
        mtc0(`CP0_COMPARE, m.count + 32'd12);
        wait_timer(1'b1);
        set_idle();
        commit_valid <= 1'b1;
        commit_pc    <= 32'h80001000;
        tick();
        set_idle();
        read_addr <= `CP0_CAUSE;
        @(negedge clk);
        compare("exc_taken after timer", 32'(exc_taken), 32'd1);
        compare("vector after timer", fetch_pc, `EXC_VECTOR);
        compare("timer exccode", {27'h0, read_data[6:2]}, 32'd0);
        step_checked();
        mtc0(`CP0_COMPARE, m.count + 32'd256);
        wait_timer(1'b0);
        report_test("timer interrupt");

        for (i = 0; i < 24; i++) begin
            r = next_rand();
            hw_int <= r[4:0];
            mtc0(`CP0_STATUS, {16'h0, 1'b0, r[9:5], 8'h0, r[10] & r[11], r[12]});
            check_field("hw_int in cause.ip", `CP0_CAUSE, 32'h00007c00, {17'h0, r[4:0], 10'h0});
            set_idle();
            commit_valid <= 1'b1;
            commit_pc    <= {r[31:13], 13'h0};
            tick();
        end
        tick();
        report_test("hardware interrupts");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/cp0_pkg.sv
common/excep_pkg.sv
rtl/exception_unit.sv
cp0/cp0.sv
rtl/pc_select.sv
rtl/cp0_top.sv
sim/tb_cp0_top.sv

/* run.sh */
#!/bin/sh
# build the CP0 testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_cp0_top -o tb_cp0_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_cp0_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1
